//--- design/router_geom_pkg.sv
package router_geom_pkg;

    localparam int V    = 4;        // vcs per port
    localparam int P    = 5;        // router ports
    localparam int P_1  = P - 1;    // no port sends to itself
    localparam int PV   = P * V;
    localparam int VV   = V * V;
    localparam int PP_1 = P * P_1;

    // destination index of input src -> physical output port
    function automatic int dest_port_num(int src, int idx);
        return (idx < src) ? idx : idx + 1;
    endfunction

    // physical port dst -> index in the P_1 wide vector seen from port src
    function automatic int dest_idx(int src, int dst);
        return (dst < src) ? dst : dst - 1;
    endfunction

endpackage

//--- design/alloc_types_pkg.sv
package alloc_types_pkg;

    // all vectors are port-major

    // one bit per input vc
    typedef logic [router_geom_pkg::PV-1:0] pv_vec_t;

    // one bit per port
    typedef logic [router_geom_pkg::P-1:0] p_vec_t;

    // one-hot destination per input port
    typedef logic [router_geom_pkg::PP_1-1:0] pp1_vec_t;

    // one-hot destination per input vc
    typedef logic [router_geom_pkg::PV*router_geom_pkg::P_1-1:0] pvp1_vec_t;

    // output-vc mask per input vc
    typedef logic [router_geom_pkg::PV*router_geom_pkg::V-1:0] pvv_vec_t;

endpackage

//--- design/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    logic [WIDTH-1:0]   prio;       // one-hot, index with highest priority
    logic [2*WIDTH-1:0] req_dbl;
    logic [2*WIDTH-1:0] grant_dbl;

    // two copies of the request so the search wraps past the top index
    assign req_dbl = {request, request};

    // lowest requesting bit at or above prio
    assign grant_dbl = req_dbl & ~(req_dbl - {{WIDTH{1'b0}}, prio});

    assign grant     = grant_dbl[WIDTH-1:0] | grant_dbl[2*WIDTH-1:WIDTH];
    assign any_grant = |request;

    // winner drops to lowest priority, its neighbour moves up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio <= {{(WIDTH-1){1'b0}}, 1'b1};
        end else if (any_grant) begin
            prio <= {grant[WIDTH-2:0], grant[WIDTH-1]};  // rotate past winner
        end
    end

endmodule

//--- design/sw_alloc_sub.sv
`timescale 1ns/100ps

module sw_alloc_sub (
    input  logic                      clk,
    input  logic                      rst_n,
    input  alloc_types_pkg::pv_vec_t   ivc_request_all,
    input  alloc_types_pkg::pv_vec_t   assigned_ovc_not_full_all,
    input  alloc_types_pkg::pvp1_vec_t dest_port_all,
    output alloc_types_pkg::pv_vec_t   ivc_granted_all,
    output alloc_types_pkg::pp1_vec_t  granted_dest_port_all,
    output alloc_types_pkg::pv_vec_t   first_arbiter_granted_ivc_all,
    output alloc_types_pkg::p_vec_t    inport_granted_all,
    output alloc_types_pkg::p_vec_t    outport_granted_all
);

    import router_geom_pkg::*;

    logic [V-1:0]   vc_masked   [P];  // requests with credit
    logic [V-1:0]   first_grant [P];  // input arbiter winners
    logic [P_1-1:0] dest_sel    [P];  // destination of each input winner
    logic [P_1-1:0] out_request [P];  // indexed by output port
    logic [P_1-1:0] out_grant   [P];
    logic [P_1-1:0] won_dest    [P];  // back in input-port view

    genvar i, j;

    generate
        for (i = 0; i < P; i++) begin : g_in
            assign vc_masked[i] = ivc_request_all[i*V +: V]
                                & assigned_ovc_not_full_all[i*V +: V];

            rr_arbiter #(
                .WIDTH (V)
            ) input_arb (
                .clk       (clk),
                .rst_n     (rst_n),
                .request   (vc_masked[i]),
                .grant     (first_grant[i]),
                .any_grant ()
            );

            // one-hot select of the winner's destination
            always_comb begin
                dest_sel[i] = '0;
                for (int v = 0; v < V; v++) begin
                    if (first_grant[i][v]) begin
                        dest_sel[i] |= dest_port_all[(i*V+v)*P_1 +: P_1];
                    end
                end
            end

            assign first_arbiter_granted_ivc_all[i*V +: V] = first_grant[i];
        end

        for (i = 0; i < P; i++) begin : g_out
            // output i collects the requests of every other input
            for (j = 0; j < P; j++) begin : g_pair
                if (j != i) begin : g_link
                    assign out_request[i][dest_idx(i, j)] = dest_sel[j][dest_idx(j, i)];
                    assign won_dest[j][dest_idx(j, i)]    = out_grant[i][dest_idx(i, j)];
                end
            end

            rr_arbiter #(
                .WIDTH (P_1)
            ) output_arb (
                .clk       (clk),
                .rst_n     (rst_n),
                .request   (out_request[i]),
                .grant     (out_grant[i]),
                .any_grant (outport_granted_all[i])
            );
        end

        for (i = 0; i < P; i++) begin : g_result
            assign granted_dest_port_all[i*P_1 +: P_1] = won_dest[i];
            assign inport_granted_all[i]               = |won_dest[i];
            // vc grant only when the output side agreed
            assign ivc_granted_all[i*V +: V] = inport_granted_all[i] ? first_grant[i] : '0;
        end
    endgenerate

endmodule

//--- design/spec_merge.sv
`timescale 1ns/100ps

module spec_merge (
    input  alloc_types_pkg::p_vec_t   nonspec_inport_granted_all,
    input  alloc_types_pkg::p_vec_t   nonspec_outport_granted_all,
    input  alloc_types_pkg::pp1_vec_t spec_granted_dest_port_pre,
    input  alloc_types_pkg::pv_vec_t  spec_ivc_granted_pre,
    input  alloc_types_pkg::p_vec_t   spec_any_ivc_grant,
    input  alloc_types_pkg::p_vec_t   valid_speculation,
    output alloc_types_pkg::pp1_vec_t spec_granted_dest_port_all,
    output alloc_types_pkg::pv_vec_t  spec_ivc_granted_all,
    output alloc_types_pkg::p_vec_t   spec_any_ivc_grant_valid
);

    import router_geom_pkg::*;

    logic [P_1-1:0] nonspec_out_busy [P];  // outputs taken, seen from input i
    logic [P_1-1:0] spec_accepted    [P];
    logic [P-1:0]   any_accepted;

    genvar i, d;

    generate
        for (i = 0; i < P; i++) begin : g_port
            for (d = 0; d < P_1; d++) begin : g_dest
                assign nonspec_out_busy[i][d] = nonspec_outport_granted_all[dest_port_num(i, d)];
            end

            // input port used by the non-speculative pass blocks everything
            assign spec_accepted[i] = nonspec_inport_granted_all[i] ? '0 :
                spec_granted_dest_port_pre[i*P_1 +: P_1] & ~nonspec_out_busy[i];

            assign any_accepted[i] = |spec_accepted[i];

            assign spec_ivc_granted_all[i*V +: V] =
                (any_accepted[i] & valid_speculation[i]) ? spec_ivc_granted_pre[i*V +: V] : '0;

            // no free output vc, no speculative traversal
            assign spec_granted_dest_port_all[i*P_1 +: P_1] =
                valid_speculation[i] ? spec_accepted[i] : '0;
        end
    endgenerate

    assign spec_any_ivc_grant_valid = any_accepted & valid_speculation & spec_any_ivc_grant;

endmodule

//--- design/spec_sw_alloc.sv
`timescale 1ns/100ps

module spec_sw_alloc (
    input  logic                       clk,
    input  logic                       rst_n,
    input  alloc_types_pkg::pv_vec_t   ivc_request_all,
    input  alloc_types_pkg::pv_vec_t   ovc_is_assigned_all,
    input  alloc_types_pkg::pv_vec_t   assigned_ovc_not_full_all,
    input  alloc_types_pkg::pvp1_vec_t dest_port_all,
    input  alloc_types_pkg::p_vec_t    valid_speculation,
    output alloc_types_pkg::pv_vec_t   ivc_granted_all,
    output alloc_types_pkg::pp1_vec_t  granted_dest_port_all,
    output alloc_types_pkg::p_vec_t    any_ivc_sw_request_granted_all,
    output alloc_types_pkg::pv_vec_t   spec_first_arbiter_granted_ivc_all,
    output alloc_types_pkg::pp1_vec_t  spec_granted_dest_port_all,
    output alloc_types_pkg::p_vec_t    spec_any_ivc_grant_valid
);

    import router_geom_pkg::*;

    logic [PV-1:0]   nonspec_request;
    logic [PV-1:0]   spec_request;
    logic [PV-1:0]   nonspec_ivc_granted;
    logic [PP_1-1:0] nonspec_dest;
    logic [P-1:0]    nonspec_inport;
    logic [P-1:0]    nonspec_outport;
    logic [PV-1:0]   spec_ivc_pre;
    logic [PP_1-1:0] spec_dest_pre;
    logic [P-1:0]    spec_inport;
    logic [PV-1:0]   spec_ivc_accepted;

    // vc already holds an output vc -> non-speculative
    assign nonspec_request = ivc_request_all & ovc_is_assigned_all;
    assign spec_request    = ivc_request_all & ~ovc_is_assigned_all;

    sw_alloc_sub nonspec_alloc (
        .clk                           (clk),
        .rst_n                         (rst_n),
        .ivc_request_all               (nonspec_request),
        .assigned_ovc_not_full_all     (assigned_ovc_not_full_all),
        .dest_port_all                 (dest_port_all),
        .ivc_granted_all               (nonspec_ivc_granted),
        .granted_dest_port_all         (nonspec_dest),
        .first_arbiter_granted_ivc_all (),
        .inport_granted_all            (nonspec_inport),
        .outport_granted_all           (nonspec_outport)
    );

    sw_alloc_sub spec_alloc (
        .clk                           (clk),
        .rst_n                         (rst_n),
        .ivc_request_all               (spec_request),
        .assigned_ovc_not_full_all     ({PV{1'b1}}),  // no credit check yet
        .dest_port_all                 (dest_port_all),
        .ivc_granted_all               (spec_ivc_pre),
        .granted_dest_port_all         (spec_dest_pre),
        .first_arbiter_granted_ivc_all (spec_first_arbiter_granted_ivc_all),
        .inport_granted_all            (spec_inport),
        .outport_granted_all           ()
    );

    spec_merge merge (
        .nonspec_inport_granted_all  (nonspec_inport),
        .nonspec_outport_granted_all (nonspec_outport),
        .spec_granted_dest_port_pre  (spec_dest_pre),
        .spec_ivc_granted_pre        (spec_ivc_pre),
        .spec_any_ivc_grant          (spec_inport),
        .valid_speculation           (valid_speculation),
        .spec_granted_dest_port_all  (spec_granted_dest_port_all),
        .spec_ivc_granted_all        (spec_ivc_accepted),
        .spec_any_ivc_grant_valid    (spec_any_ivc_grant_valid)
    );

    // passes never overlap after the merge, a plain or is enough
    assign ivc_granted_all                = nonspec_ivc_granted | spec_ivc_accepted;
    assign granted_dest_port_all          = nonspec_dest | spec_granted_dest_port_all;
    assign any_ivc_sw_request_granted_all = nonspec_inport | spec_any_ivc_grant_valid;

endmodule

//--- design/spec_vc_alloc.sv
`timescale 1ns/100ps

module spec_vc_alloc (
    input  logic                      clk,
    input  logic                      rst_n,
    input  alloc_types_pkg::pvv_vec_t masked_ovc_request_all,
    input  alloc_types_pkg::pv_vec_t  spec_first_arbiter_granted_ivc_all,
    input  alloc_types_pkg::pp1_vec_t spec_granted_dest_port_all,
    input  alloc_types_pkg::p_vec_t   spec_any_ivc_grant_valid,
    output alloc_types_pkg::p_vec_t   valid_speculation,
    output alloc_types_pkg::pvv_vec_t granted_ovc_num_all,
    output alloc_types_pkg::pv_vec_t  ivc_num_getting_ovc_grant,
    output alloc_types_pkg::pv_vec_t  ovc_allocated_all
);

    import router_geom_pkg::*;

    logic [V-1:0] ovc_request [P];  // candidate ovcs of the speculative winner
    logic [V-1:0] ovc_grant   [P];
    logic [V-1:0] ovc_chosen  [P];  // kept only if the switch grant held

    genvar i, v;

    generate
        for (i = 0; i < P; i++) begin : g_port
            always_comb begin
                ovc_request[i] = '0;
                for (int k = 0; k < V; k++) begin
                    if (spec_first_arbiter_granted_ivc_all[i*V+k]) begin
                        ovc_request[i] |= masked_ovc_request_all[(i*V+k)*V +: V];
                    end
                end
            end

            // empty candidate mask means the speculation is useless
            rr_arbiter #(
                .WIDTH (V)
            ) ovc_arb (
                .clk       (clk),
                .rst_n     (rst_n),
                .request   (ovc_request[i]),
                .grant     (ovc_grant[i]),
                .any_grant (valid_speculation[i])
            );

            assign ovc_chosen[i] = spec_any_ivc_grant_valid[i] ? ovc_grant[i] : '0;

            assign ivc_num_getting_ovc_grant[i*V +: V] =
                spec_any_ivc_grant_valid[i] ? spec_first_arbiter_granted_ivc_all[i*V +: V] : '0;

            // same mask copied to each vc of the port
            for (v = 0; v < V; v++) begin : g_copy
                assign granted_ovc_num_all[i*VV + v*V +: V] = ovc_chosen[i];
            end
        end
    endgenerate

    // steer each choice to its output port
    always_comb begin
        ovc_allocated_all = '0;
        for (int i = 0; i < P; i++) begin
            for (int d = 0; d < P_1; d++) begin
                if (spec_granted_dest_port_all[i*P_1+d]) begin
                    ovc_allocated_all[dest_port_num(i, d)*V +: V] |= ovc_chosen[i];
                end
            end
        end
    end

endmodule

//--- design/comb_spec_allocator.sv
`timescale 1ns/100ps

module comb_spec_allocator (
    input  logic                       clk,
    input  logic                       rst_n,
    input  alloc_types_pkg::pv_vec_t   ivc_request_all,
    input  alloc_types_pkg::pv_vec_t   ovc_is_assigned_all,
    input  alloc_types_pkg::pv_vec_t   assigned_ovc_not_full_all,
    input  alloc_types_pkg::pvp1_vec_t dest_port_all,
    input  alloc_types_pkg::pvv_vec_t  masked_ovc_request_all,
    output alloc_types_pkg::pv_vec_t   ivc_num_getting_sw_grant,
    output alloc_types_pkg::pp1_vec_t  granted_dest_port_all,
    output alloc_types_pkg::p_vec_t    any_ivc_sw_request_granted_all,
    output alloc_types_pkg::pv_vec_t   ivc_num_getting_ovc_grant,
    output alloc_types_pkg::pvv_vec_t  granted_ovc_num_all,
    output alloc_types_pkg::pv_vec_t   ovc_allocated_all
);

    import router_geom_pkg::*;

    logic [PV-1:0]   spec_first_arbiter_granted_ivc_all;
    logic [PP_1-1:0] spec_granted_dest_port_all;
    logic [P-1:0]    spec_any_ivc_grant_valid;
    logic [P-1:0]    valid_speculation;  // from the ovc side, per input port

    spec_sw_alloc sw_alloc (
        .clk                                (clk),
        .rst_n                              (rst_n),
        .ivc_request_all                    (ivc_request_all),
        .ovc_is_assigned_all                (ovc_is_assigned_all),
        .assigned_ovc_not_full_all          (assigned_ovc_not_full_all),
        .dest_port_all                      (dest_port_all),
        .valid_speculation                  (valid_speculation),
        .ivc_granted_all                    (ivc_num_getting_sw_grant),
        .granted_dest_port_all              (granted_dest_port_all),
        .any_ivc_sw_request_granted_all     (any_ivc_sw_request_granted_all),
        .spec_first_arbiter_granted_ivc_all (spec_first_arbiter_granted_ivc_all),
        .spec_granted_dest_port_all         (spec_granted_dest_port_all),
        .spec_any_ivc_grant_valid           (spec_any_ivc_grant_valid)
    );

    spec_vc_alloc vc_alloc (
        .clk                                (clk),
        .rst_n                              (rst_n),
        .masked_ovc_request_all             (masked_ovc_request_all),
        .spec_first_arbiter_granted_ivc_all (spec_first_arbiter_granted_ivc_all),
        .spec_granted_dest_port_all         (spec_granted_dest_port_all),
        .spec_any_ivc_grant_valid           (spec_any_ivc_grant_valid),
        .valid_speculation                  (valid_speculation),
        .granted_ovc_num_all                (granted_ovc_num_all),
        .ivc_num_getting_ovc_grant          (ivc_num_getting_ovc_grant),
        .ovc_allocated_all                  (ovc_allocated_all)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;  // released in step with the stimulus
    end

endmodule

//--- verification/alloc_asserts.sv
`timescale 1ns/100ps

module alloc_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input alloc_types_pkg::pv_vec_t   ivc_request_all,
    input alloc_types_pkg::pv_vec_t   ovc_is_assigned_all,
    input alloc_types_pkg::pv_vec_t   assigned_ovc_not_full_all,
    input alloc_types_pkg::pvp1_vec_t dest_port_all,
    input alloc_types_pkg::pvv_vec_t  masked_ovc_request_all,
    input alloc_types_pkg::pv_vec_t   ivc_num_getting_sw_grant,
    input alloc_types_pkg::pp1_vec_t  granted_dest_port_all,
    input alloc_types_pkg::p_vec_t    any_ivc_sw_request_granted_all,
    input alloc_types_pkg::pv_vec_t   ivc_num_getting_ovc_grant,
    input alloc_types_pkg::pvv_vec_t  granted_ovc_num_all,
    input alloc_types_pkg::pv_vec_t   ovc_allocated_all
);

    import router_geom_pkg::*;

    int fail_count = 0;

    logic          first_cycle;    // first sampled edge out of reset
    logic [PV-1:0] nonspec_ok;     // assigned and holding credit
    logic [PV-1:0] ovc_allowed;    // candidate ovcs of the winners, per output port
    logic [PV-1:0] ovc_taken;
    logic [PV-1:0] ovc_double;     // output vc picked by two inputs
    logic [P-1:0]  out_claim [P];  // inputs holding each output

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_cycle <= 1'b1;
        end else begin
            first_cycle <= 1'b0;
        end
    end

    assign nonspec_ok = ovc_is_assigned_all & assigned_ovc_not_full_all;

    // output o seen from input i sits at index o below i and o-1 above it
    always_comb begin
        ovc_allowed = '0;
        ovc_taken   = '0;
        ovc_double  = '0;
        for (int o = 0; o < P; o++) begin
            out_claim[o] = '0;
            for (int i = 0; i < P; i++) begin
                if (i != o) begin
                    if (granted_dest_port_all[i*P_1 + ((o < i) ? o : o - 1)]) begin
                        out_claim[o][i] = 1'b1;
                        ovc_double[o*V +: V] |= ovc_taken[o*V +: V]
                                              & granted_ovc_num_all[i*VV +: V];
                        ovc_taken[o*V +: V]  |= granted_ovc_num_all[i*VV +: V];
                        for (int k = 0; k < V; k++) begin
                            if (ivc_num_getting_ovc_grant[i*V+k]) begin
                                ovc_allowed[o*V +: V] |= masked_ovc_request_all[(i*V+k)*V +: V];
                            end
                        end
                    end
                end
            end
        end
    end

    genvar gi;

    generate
        for (gi = 0; gi < P; gi++) begin : g_port
            localparam logic [PV-1:0] OWN = {{(PV-V){1'b0}}, {V{1'b1}}} << (gi*V);

            logic [V-1:0] req;
            logic [V-1:0] sw;
            logic         others_idle;
            logic         lone_full;  // every vc non-spec with credit and no other port busy
            logic         rr_pair;    // two non-spec vcs and no other port busy

            assign req         = ivc_request_all[gi*V +: V];
            assign sw          = ivc_num_getting_sw_grant[gi*V +: V];
            assign others_idle = (ivc_request_all & ~OWN) == '0;
            assign lone_full   = others_idle && req == '1 && nonspec_ok[gi*V +: V] == '1;
            assign rr_pair     = others_idle && $countones(req) == 2
                               && (req & ~nonspec_ok[gi*V +: V]) == '0;

            a_first_vc0: assert property (@(posedge clk) disable iff (!rst_n)
                first_cycle && lone_full |-> sw == V'(1))
            else begin
                $error("port %0d: first grant after reset is not vc 0", gi);
                fail_count++;
            end

            a_port_excl: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(sw) && $onehot0(granted_dest_port_all[gi*P_1 +: P_1])
                && $onehot0(out_claim[gi])
                && any_ivc_sw_request_granted_all[gi] == |sw
                && any_ivc_sw_request_granted_all[gi] == |granted_dest_port_all[gi*P_1 +: P_1])
            else begin
                $error("port %0d: grants are not exclusive", gi);
                fail_count++;
            end

            // every vc of the port carries the same output vc mask
            a_port_ovc: assert property (@(posedge clk) disable iff (!rst_n)
                (|ivc_num_getting_ovc_grant[gi*V +: V])
                    == $onehot(granted_ovc_num_all[gi*VV +: V])
                && granted_ovc_num_all[gi*VV +: VV] == {V{granted_ovc_num_all[gi*VV +: V]}})
            else begin
                $error("port %0d: output vc choice is not one-hot or not copied to every vc",
                       gi);
                fail_count++;
            end

            a_rr_fair: assert property (@(posedge clk) disable iff (!rst_n)
                rr_pair && $past(rr_pair) && $stable(req) |-> (sw | $past(sw)) == req)
            else begin
                $error("port %0d: a requesting vc starved for two cycles", gi);
                fail_count++;
            end
        end
    endgenerate

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        ivc_request_all == '0 |-> ivc_num_getting_sw_grant == '0 && granted_dest_port_all == '0
        && any_ivc_sw_request_granted_all == '0 && ivc_num_getting_ovc_grant == '0
        && granted_ovc_num_all == '0 && ovc_allocated_all == '0)
    else begin
        $error("outputs active with no request");
        fail_count++;
    end

    a_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (ivc_num_getting_sw_grant & ~ivc_request_all) == '0
        && (ivc_num_getting_sw_grant & ovc_is_assigned_all & ~assigned_ovc_not_full_all) == '0)
    else begin
        $error("switch grant without request or without credit");
        fail_count++;
    end

    a_spec_ovc: assert property (@(posedge clk) disable iff (!rst_n)
        ivc_num_getting_ovc_grant == (ivc_num_getting_sw_grant & ~ovc_is_assigned_all))
    else begin
        $error("output vc grants differ from speculative switch grants");
        fail_count++;
    end

    // allocated map is exactly the steered choices, all inside the winner's mask
    a_ovc_mask: assert property (@(posedge clk) disable iff (!rst_n)
        (ovc_allocated_all & ~ovc_allowed) == '0 && ovc_allocated_all == ovc_taken)
    else begin
        $error("output vc allocation differs from the chosen output vcs or their masks");
        fail_count++;
    end

    a_ovc_unique: assert property (@(posedge clk) disable iff (!rst_n)
        ovc_double == '0)
    else begin
        $error("output vc claimed by two inputs");
        fail_count++;
    end

    a_sole_granted: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(ivc_request_all) && (ivc_request_all & ~nonspec_ok) == '0
        |-> ivc_num_getting_sw_grant == ivc_request_all)
    else begin
        $error("sole request with credit was not granted");
        fail_count++;
    end

endmodule

bind comb_spec_allocator alloc_asserts asserts_i (.*);

//--- verification/alloc_tb.sv
`timescale 1ns/100ps

module alloc_tb;

    import router_geom_pkg::*;
    import alloc_types_pkg::*;

    localparam int TEST_CYCLES    = 200;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES * 11 / 10;  // 10% margin

    logic      clk;
    logic      rst_n;
    pv_vec_t   ivc_request_all;
    pv_vec_t   ovc_is_assigned_all;
    pv_vec_t   assigned_ovc_not_full_all;
    pvp1_vec_t dest_port_all;
    pvv_vec_t  masked_ovc_request_all;
    pv_vec_t   ivc_num_getting_sw_grant;
    pp1_vec_t  granted_dest_port_all;
    p_vec_t    any_ivc_sw_request_granted_all;
    pv_vec_t   ivc_num_getting_ovc_grant;
    pvv_vec_t  granted_ovc_num_all;
    pv_vec_t   ovc_allocated_all;

    int cycle_count  = 0;
    int tests_failed = 0;
    int base_fails   = 0;

    tb_clock_gen clock_gen_i (.clk(clk), .rst_n(rst_n));

    comb_spec_allocator dut_i (.*);

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        ivc_request_all           = '0;
        ovc_is_assigned_all       = '0;
        assigned_ovc_not_full_all = '0;
        dest_port_all             = '0;
        masked_ovc_request_all    = '0;
    endtask

    task automatic drive_vc(int port, int vc, bit assigned, bit credit, int dest,
                            logic [V-1:0] mask);
        int n;
        n = port * V + vc;
        ivc_request_all[n]               = 1'b1;
        ovc_is_assigned_all[n]           = assigned;
        assigned_ovc_not_full_all[n]     = credit;
        dest_port_all[n*P_1 +: P_1]      = '0;
        dest_port_all[n*P_1 + dest]      = 1'b1;  // one-hot destination
        masked_ovc_request_all[n*V +: V] = mask;
    endtask

    task automatic drive_random(int req_pct, int assigned_pct, int credit_pct);
        clear_inputs();
        for (int p = 0; p < P; p++) begin
            for (int v = 0; v < V; v++) begin
                if ($urandom_range(99) < req_pct) begin
                    drive_vc(p, v, $urandom_range(99) < assigned_pct,
                             $urandom_range(99) < credit_pct,
                             $urandom_range(P_1 - 1), V'($urandom_range(2**V - 1)));
                end
            end
        end
    endtask

    // one assigned vc with credit, nothing else in the router
    task automatic drive_sole();
        clear_inputs();
        drive_vc($urandom_range(P - 1), $urandom_range(V - 1), 1'b1, 1'b1,
                 $urandom_range(P_1 - 1), '1);
    endtask

    task automatic finish_test(string name);
        int errs;
        errs = dut_i.asserts_i.fail_count - base_fails;
        if (errs != 0) begin
            $display("FAIL %s: assertion failures expected 0 actual %0d", name, errs);
            tests_failed++;
        end else begin
            $display("pass %s", name);
        end
        base_fails = dut_i.asserts_i.fail_count;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd00c));
        clear_inputs();
        wait (rst_n === 1'b1);

        // port 2 full on every vc, first cycle out of reset
        for (int v = 0; v < V; v++) begin
            drive_vc(2, v, 1'b1, 1'b1, 1, '1);
        end
        step();
        clear_inputs();
        repeat (TEST_CYCLES - 1) step();
        finish_test("reset_idle");

        repeat (TEST_CYCLES) begin
            drive_sole();
            step();
        end
        finish_test("single_nonspec");

        for (int c = 0; c < TEST_CYCLES; c++) begin
            clear_inputs();
            drive_vc((c / 40) % P, (c / 40) % V, 1'b1, 1'b1, (c / 40) % P_1, '1);
            drive_vc((c / 40) % P, (c / 40 + 2) % V, 1'b1, 1'b1, (c / 40) % P_1, '1);
            step();
        end
        finish_test("rr_fairness");

        repeat (TEST_CYCLES) begin
            drive_random(60, 60, 70);
            step();
        end
        finish_test("conflict_random");

        repeat (TEST_CYCLES) begin
            drive_random(60, 20, 80);  // mostly speculative
            step();
        end
        finish_test("spec_vc");

        for (int c = 0; c < TEST_CYCLES; c++) begin
            if (c % 2 == 0) begin
                drive_sole();
            end else begin
                drive_random(70, 100, 30);  // credit mostly gone
            end
            step();
        end
        finish_test("backpressure");

        $display("tests %0d failed %0d assertion failures %0d",
                 NUM_TESTS, tests_failed, dut_i.asserts_i.fail_count);
        if (tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/router_geom_pkg.sv
design/alloc_types_pkg.sv
design/rr_arbiter.sv
design/sw_alloc_sub.sv
design/spec_merge.sv
design/spec_sw_alloc.sv
design/spec_vc_alloc.sv
design/comb_spec_allocator.sv
verification/tb_clock_gen.sv
verification/alloc_asserts.sv
verification/alloc_tb.sv
